//--- logic/tx_ctrl_pkg.sv
// shared widths, 802.11 codes and struct types, imported by every module of the tx control block
package tx_ctrl_pkg;

  // word address width of the phy transmitter header port
  localparam int TX_ADDR_W = 10;

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] duration_t;
  typedef logic [14:0] timeout_t;
  typedef logic [3:0]  retry_cnt_t;
  typedef logic [63:0] tx_word_t;

  // frame control type field
  localparam logic [1:0] FC_TYPE_MGMT = 2'b00;
  localparam logic [1:0] FC_TYPE_CTRL = 2'b01;
  localparam logic [1:0] FC_TYPE_DATA = 2'b10;

  // subtypes of interest, control ones except the no-ack action
  localparam logic [3:0] SUBTYPE_BAR          = 4'b1000;
  localparam logic [3:0] SUBTYPE_BA           = 4'b1001;
  localparam logic [3:0] SUBTYPE_PSPOLL       = 4'b1010;
  localparam logic [3:0] SUBTYPE_RTS          = 4'b1011;
  localparam logic [3:0] SUBTYPE_CTS          = 4'b1100;
  localparam logic [3:0] SUBTYPE_ACK          = 4'b1101;
  localparam logic [3:0] SUBTYPE_ACTION_NOACK = 4'b1110;

  // psdu lengths in bytes
  localparam logic [15:0] ACK_SIGNAL_LEN = 16'd14;
  localparam logic [15:0] RTS_SIGNAL_LEN = 16'd20;

  // ack and cts always go out at 6 Mbps, six ofdm symbols
  localparam logic [3:0] ACK_RATE_CODE = 4'b1011;
  localparam logic [2:0] ACK_N_SYM     = 3'd6;
  // 24 us of ack body at 100 clocks per us
  localparam timeout_t   ACK_RX_BASE_CYCLES = 15'd2400;

  // header word addresses seen on tx_word_addr
  localparam logic [TX_ADDR_W-1:0] HDR_SIGNAL_ADDR  = 10'd0;
  localparam logic [TX_ADDR_W-1:0] HDR_ADDR_LO_ADDR = 10'd2;
  localparam logic [TX_ADDR_W-1:0] HDR_ADDR_HI_ADDR = 10'd3;

  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_DATA,
    KIND_MGMT,
    KIND_BAR,
    KIND_BA,
    KIND_PSPOLL,
    KIND_RTS
  } frame_kind_e;

  // frame currently coming out of the receiver
  typedef struct packed {
    logic        sig_valid;
    logic [15:0] signal_len;
    logic        fcs_valid;
    logic        fcs_in_strobe;
    logic [1:0]  fc_type;
    logic [3:0]  fc_subtype;
    logic        more_frag;
    duration_t   duration;
    mac_addr_t   addr1;
    mac_addr_t   addr2;
  } rx_frame_t;

  typedef struct packed {
    logic [6:0] preamble_sig_time;
    logic [4:0] ofdm_symbol_time;
    logic [6:0] sifs_time;
    timeout_t   send_ack_wait_top;
    timeout_t   sig_valid_timeout_top;
    timeout_t   ack_timeout_adj;
    duration_t  duration_extra;
  } timing_cfg_t;

  // what we answer to
  typedef struct packed {
    frame_kind_e kind;
    logic        more_frag;
    duration_t   duration;
    mac_addr_t   ack_addr;
  } rx_summary_t;

  typedef struct packed {
    logic       fail;
    retry_cnt_t num_retrans;
  } tx_status_t;

endpackage

//--- logic/frame_classifier.sv
// classifies received frames, flags the ones needing an ack or cts and latches their summary
module frame_classifier
  import tx_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  rx_frame_t   rx,
  input  mac_addr_t   self_mac_addr,
  input  logic        cts_torts_disable,
  input  logic        capture_en,
  output logic        respond_req,
  output rx_summary_t summary
);

  frame_kind_e kind;
  logic        kind_responds;

  // type and subtype to frame kind
  always_comb begin
    kind = KIND_NONE;
    case (rx.fc_type)
      FC_TYPE_DATA: kind = KIND_DATA;
      FC_TYPE_MGMT: begin
        // no-ack action frames never get a response
        if (rx.fc_subtype != SUBTYPE_ACTION_NOACK) begin
          kind = KIND_MGMT;
        end
      end
      FC_TYPE_CTRL: begin
        case (rx.fc_subtype)
          SUBTYPE_BAR:    kind = KIND_BAR;
          SUBTYPE_BA:     kind = KIND_BA;
          SUBTYPE_PSPOLL: kind = KIND_PSPOLL;
          SUBTYPE_RTS: begin
            // a real rts is 20 bytes long
            if (rx.signal_len == RTS_SIGNAL_LEN) begin
              kind = KIND_RTS;
            end
          end
          default: kind = KIND_NONE;
        endcase
      end
      default: kind = KIND_NONE;
    endcase
  end

  // rts only answered while cts is enabled
  assign kind_responds = (kind != KIND_NONE) && ((kind != KIND_RTS) || !cts_torts_disable);
  assign respond_req   = rx.fcs_valid && kind_responds && (rx.addr1 == self_mac_addr);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      summary.kind <= KIND_NONE;
    end else if (capture_en) begin
      summary.kind      <= kind;
      summary.more_frag <= rx.more_frag;
      summary.duration  <= rx.duration;
      // ra of the response is the ta of the received frame
      summary.ack_addr  <= rx.addr2;
    end
  end

endmodule

//--- logic/response_builder.sv
// builds the ack or cts header words and hands them to the phy transmitter by word address
module response_builder
  import tx_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  timing_cfg_t          cfg,
  input  rx_summary_t          summary,
  input  logic                 in_send_ack,
  input  logic [TX_ADDR_W-1:0] tx_word_addr,
  output tx_word_t             tx_word
);

  logic [8:0] ackcts_time;
  duration_t  dur_left;
  duration_t  resp_duration;
  logic [3:0] resp_subtype;

  // airtime of our own ack or cts in us
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ackcts_time <= '0;
    end else begin
      ackcts_time <= 9'(cfg.preamble_sig_time) + 9'(cfg.ofdm_symbol_time) * 9'(ACK_N_SYM);
    end
  end

  // received nav minus our response and sifs, zero stays zero
  assign dur_left = (summary.duration == '0) ? '0 :
                    summary.duration - 16'(ackcts_time) - 16'(cfg.sifs_time);

  always_comb begin
    resp_subtype  = SUBTYPE_ACK;
    resp_duration = cfg.duration_extra + dur_left;
    case (summary.kind)
      KIND_DATA, KIND_MGMT: begin
        // last fragment closes the nav
        if (!summary.more_frag) begin
          resp_duration = cfg.duration_extra;
        end
      end
      KIND_RTS: resp_subtype = SUBTYPE_CTS;
      default: resp_subtype = SUBTYPE_ACK;
    endcase
  end

  // one cycle behind the address, holds on unused words
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tx_word <= '0;
    end else if (in_send_ack) begin
      case (tx_word_addr)
        HDR_SIGNAL_ADDR: begin
          // even parity over rate and length of the signal field
          tx_word <= {32'h0, 14'h0, ^{ACK_RATE_CODE, ACK_SIGNAL_LEN[11:0]},
                      ACK_SIGNAL_LEN[11:0], 1'b0, ACK_RATE_CODE};
        end
        HDR_ADDR_LO_ADDR: begin
          tx_word <= {summary.ack_addr[31:0], resp_duration, 8'h0, resp_subtype,
                      FC_TYPE_CTRL, 2'b00};
        end
        HDR_ADDR_HI_ADDR: begin
          tx_word <= {48'h0, summary.ack_addr[47:32]};
        end
        default: tx_word <= tx_word;
      endcase
    end
  end

  // a cts header only ever answers a captured rts
  assert property (@(posedge clk) disable iff (!rstn)
    (in_send_ack && tx_word_addr == HDR_ADDR_LO_ADDR) |=>
      (tx_word[7:4] != SUBTYPE_CTS || summary.kind == KIND_RTS));

endmodule

//--- logic/ack_wait_fsm.sv
// control FSM for sending responses, waiting for acks, timeouts and retransmission status
module ack_wait_fsm
  import tx_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  timing_cfg_t cfg,
  input  rx_frame_t   rx,
  input  mac_addr_t   self_mac_addr,
  input  logic        respond_req,
  input  logic        phy_tx_done,
  input  logic        pulse_tx_bb_end,
  input  logic        cts_toself_bb_is_ongoing,
  input  logic        tx_pkt_need_ack,
  input  retry_cnt_t  tx_pkt_retrans_limit,
  input  logic        backoff_done,
  input  logic        quit_retrans,
  output logic        capture_en,
  output logic        in_send_ack,
  output logic        start_tx_ack,
  output logic        ack_cts_is_ongoing,
  output logic        ack_tx_flag,
  output logic        retrans_trigger,
  output logic        start_retrans,
  output logic        retrans_in_progress,
  output logic        tx_try_complete,
  output tx_status_t  tx_status,
  output logic        tx_control_state_idle
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_ACK,
    ST_SEND_ACK_DO,
    ST_JUDGE,
    ST_WAIT_BB_DONE,
    ST_WAIT_SIG,
    ST_WAIT_ACK,
    ST_WAIT_BACKOFF
  } state_e;

  state_e     state;
  timeout_t   wait_cnt;
  timeout_t   ack_window;
  retry_cnt_t num_retrans;
  retry_cnt_t num_retrans_lock;
  logic       fail_lock;
  logic       retrans_started;
  logic       sig_hit;
  logic       ack_valid_rx;
  logic       timeout_hit;
  logic       at_limit;

  // summary follows the receiver until we commit to a response
  assign capture_en            = (state == ST_IDLE);
  assign ack_cts_is_ongoing    = (state == ST_SEND_ACK) || (state == ST_SEND_ACK_DO);
  assign in_send_ack           = ack_cts_is_ongoing;
  assign tx_control_state_idle = (state == ST_IDLE) && !retrans_started;

  assign sig_hit      = rx.sig_valid && (rx.signal_len == ACK_SIGNAL_LEN);
  assign ack_valid_rx = rx.fcs_in_strobe && (rx.fc_type == FC_TYPE_CTRL) &&
                        (rx.fc_subtype == SUBTYPE_ACK) && (rx.addr1 == self_mac_addr);

  // either wait running out
  assign timeout_hit = ((state == ST_WAIT_SIG) && (wait_cnt == cfg.sig_valid_timeout_top)) ||
                       ((state == ST_WAIT_ACK) && (wait_cnt == ack_window));
  // a limit of zero means no retries at all
  assign at_limit = (tx_pkt_retrans_limit == '0) || (num_retrans >= tx_pkt_retrans_limit);

  // close the try, status picked up one cycle later
  task automatic finish_try(input logic fail);
    tx_try_complete     <= 1'b1;
    fail_lock           <= fail;
    num_retrans_lock    <= num_retrans;
    num_retrans         <= '0;
    retrans_in_progress <= 1'b0;
    retrans_started     <= 1'b0;
    retrans_trigger     <= 1'b0;
    state               <= ST_IDLE;
  endtask

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state               <= ST_IDLE;
      wait_cnt            <= '0;
      ack_window          <= '0;
      num_retrans         <= '0;
      num_retrans_lock    <= '0;
      fail_lock           <= 1'b0;
      retrans_started     <= 1'b0;
      retrans_in_progress <= 1'b0;
      retrans_trigger     <= 1'b0;
      start_retrans       <= 1'b0;
      start_tx_ack        <= 1'b0;
      ack_tx_flag         <= 1'b0;
      tx_try_complete     <= 1'b0;
      tx_status           <= '0;
    end else begin
      // pulses default low
      tx_try_complete       <= 1'b0;
      start_retrans         <= 1'b0;
      start_tx_ack          <= 1'b0;
      tx_status.fail        <= fail_lock;
      tx_status.num_retrans <= num_retrans_lock;

      case (state)
        ST_IDLE: begin
          ack_tx_flag <= 1'b0;
          wait_cnt    <= '0;
          if (respond_req) begin
            state <= ST_SEND_ACK;
          end else if (phy_tx_done && !cts_toself_bb_is_ongoing) begin
            // our own frame just left the phy
            state <= ST_JUDGE;
          end else if (quit_retrans && retrans_in_progress) begin
            finish_try(1'b1);
          end else if (backoff_done && retrans_in_progress && !retrans_started) begin
            state <= ST_WAIT_BACKOFF;
          end
        end
        ST_SEND_ACK: begin
          // sifs alignment before kicking the phy
          if (wait_cnt != cfg.send_ack_wait_top) begin
            wait_cnt <= wait_cnt + 1'b1;
          end else begin
            state <= ST_SEND_ACK_DO;
          end
        end
        ST_SEND_ACK_DO: begin
          // flag low only in the first cycle here
          start_tx_ack <= !ack_tx_flag;
          ack_tx_flag  <= 1'b1;
          if (phy_tx_done) begin
            state <= ST_IDLE;
          end
        end
        ST_JUDGE: begin
          retrans_started <= 1'b0;
          if (tx_pkt_need_ack) begin
            state               <= ST_WAIT_BB_DONE;
            retrans_in_progress <= 1'b1;
          end else begin
            finish_try(1'b0);
          end
        end
        ST_WAIT_BB_DONE: begin
          if (pulse_tx_bb_end) begin
            state    <= ST_WAIT_SIG;
            wait_cnt <= '0;
          end
        end
        ST_WAIT_SIG: begin
          if (sig_hit && (wait_cnt < cfg.sig_valid_timeout_top)) begin
            state      <= ST_WAIT_ACK;
            wait_cnt   <= '0;
            ack_window <= ACK_RX_BASE_CYCLES + cfg.ack_timeout_adj;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ST_WAIT_ACK: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (ack_valid_rx && (wait_cnt < ack_window)) begin
            finish_try(1'b0);
          end
        end
        ST_WAIT_BACKOFF: begin
          if (quit_retrans) begin
            finish_try(1'b1);
          end else begin
            start_retrans   <= 1'b1;
            retrans_started <= 1'b1;
            retrans_trigger <= 1'b0;
            state           <= ST_IDLE;
          end
        end
      endcase

      // both waits share the retry decision
      if (timeout_hit) begin
        if (at_limit) begin
          finish_try(1'b1);
        end else begin
          num_retrans     <= num_retrans + 1'b1;
          retrans_trigger <= 1'b1;
          state           <= ST_IDLE;
        end
      end
    end
  end

  // phy start request never stretches
  assert property (@(posedge clk) disable iff (!rstn) start_tx_ack |=> !start_tx_ack);

  // a try cannot end and restart in the same cycle
  assert property (@(posedge clk) disable iff (!rstn) !(tx_try_complete && start_retrans));

endmodule

//--- logic/tx_control_top.sv
// top of the mac low-layer tx control, ties classifier, header builder and FSM to the ports
module tx_control_top
  import tx_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  rx_frame_t            rx,
  input  mac_addr_t            self_mac_addr,
  input  timing_cfg_t          cfg,
  input  logic                 cts_torts_disable,
  input  logic                 phy_tx_done,
  input  logic                 pulse_tx_bb_end,
  input  logic                 cts_toself_bb_is_ongoing,
  input  logic                 tx_pkt_need_ack,
  input  retry_cnt_t           tx_pkt_retrans_limit,
  input  logic                 backoff_done,
  input  logic                 quit_retrans,
  input  logic [TX_ADDR_W-1:0] tx_word_addr,
  output tx_word_t             tx_word,
  output logic                 start_tx_ack,
  output logic                 ack_cts_is_ongoing,
  output logic                 ack_tx_flag,
  output logic                 retrans_trigger,
  output logic                 start_retrans,
  output logic                 retrans_in_progress,
  output logic                 tx_try_complete,
  output tx_status_t           tx_status,
  output logic                 tx_control_state_idle
);

  logic        respond_req;
  logic        capture_en;
  logic        in_send_ack;
  rx_summary_t summary;

  // response decision and captured frame
  frame_classifier u_frame_classifier (
    .clk               (clk),
    .rstn              (rstn),
    .rx                (rx),
    .self_mac_addr     (self_mac_addr),
    .cts_torts_disable (cts_torts_disable),
    .capture_en        (capture_en),
    .respond_req       (respond_req),
    .summary           (summary)
  );

  // header words for the phy
  response_builder u_response_builder (
    .clk          (clk),
    .rstn         (rstn),
    .cfg          (cfg),
    .summary      (summary),
    .in_send_ack  (in_send_ack),
    .tx_word_addr (tx_word_addr),
    .tx_word      (tx_word)
  );

  ack_wait_fsm u_ack_wait_fsm (
    .clk                      (clk),
    .rstn                     (rstn),
    .cfg                      (cfg),
    .rx                       (rx),
    .self_mac_addr            (self_mac_addr),
    .respond_req              (respond_req),
    .phy_tx_done              (phy_tx_done),
    .pulse_tx_bb_end          (pulse_tx_bb_end),
    .cts_toself_bb_is_ongoing (cts_toself_bb_is_ongoing),
    .tx_pkt_need_ack          (tx_pkt_need_ack),
    .tx_pkt_retrans_limit     (tx_pkt_retrans_limit),
    .backoff_done             (backoff_done),
    .quit_retrans             (quit_retrans),
    .capture_en               (capture_en),
    .in_send_ack              (in_send_ack),
    .start_tx_ack             (start_tx_ack),
    .ack_cts_is_ongoing       (ack_cts_is_ongoing),
    .ack_tx_flag              (ack_tx_flag),
    .retrans_trigger          (retrans_trigger),
    .start_retrans            (start_retrans),
    .retrans_in_progress      (retrans_in_progress),
    .tx_try_complete          (tx_try_complete),
    .tx_status                (tx_status),
    .tx_control_state_idle    (tx_control_state_idle)
  );

endmodule

//--- bench/tb_clock_gen.sv
// clock and reset source for the tx control testbench, 20 unit period, reset held 3 cycles
module tb_clock_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // low for the first three rising edges
  initial begin
    rstn = 1'b0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

//--- bench/tb_tx_control.sv
// testbench for tx_control_top, drives ack/cts responses and ack-wait tries and checks them
module tb_tx_control
  import tx_ctrl_pkg::*;
();

  typedef enum int {
    W_START_TX_ACK,
    W_TRY_COMPLETE,
    W_RETRANS_TRIGGER,
    W_START_RETRANS
  } watch_e;

  logic        clk;
  logic        rstn;
  rx_frame_t   rx;
  mac_addr_t   self_addr;
  timing_cfg_t cfg;
  logic        cts_torts_disable;
  logic        phy_tx_done;
  logic        pulse_tx_bb_end;
  logic        cts_toself_bb_is_ongoing;
  logic        tx_pkt_need_ack;
  retry_cnt_t  tx_pkt_retrans_limit;
  logic        backoff_done;
  logic        quit_retrans;
  logic [9:0]  tx_word_addr;
  tx_word_t    tx_word;
  logic        start_tx_ack;
  logic        ack_cts_is_ongoing;
  logic        ack_tx_flag;
  logic        retrans_trigger;
  logic        start_retrans;
  logic        retrans_in_progress;
  logic        tx_try_complete;
  tx_status_t  tx_status;
  logic        tx_control_state_idle;

  integer    seed;
  int        errors = 0;
  int        timeouts = 0;
  int        edges;
  int        model_retries;
  mac_addr_t peer;
  duration_t dur;

  tb_clock_gen u_clock_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  tx_control_top u_tx_control_top (
    .clk                      (clk),
    .rstn                     (rstn),
    .rx                       (rx),
    .self_mac_addr            (self_addr),
    .cfg                      (cfg),
    .cts_torts_disable        (cts_torts_disable),
    .phy_tx_done              (phy_tx_done),
    .pulse_tx_bb_end          (pulse_tx_bb_end),
    .cts_toself_bb_is_ongoing (cts_toself_bb_is_ongoing),
    .tx_pkt_need_ack          (tx_pkt_need_ack),
    .tx_pkt_retrans_limit     (tx_pkt_retrans_limit),
    .backoff_done             (backoff_done),
    .quit_retrans             (quit_retrans),
    .tx_word_addr             (tx_word_addr),
    .tx_word                  (tx_word),
    .start_tx_ack             (start_tx_ack),
    .ack_cts_is_ongoing       (ack_cts_is_ongoing),
    .ack_tx_flag              (ack_tx_flag),
    .retrans_trigger          (retrans_trigger),
    .start_retrans            (start_retrans),
    .retrans_in_progress      (retrans_in_progress),
    .tx_try_complete          (tx_try_complete),
    .tx_status                (tx_status),
    .tx_control_state_idle    (tx_control_state_idle)
  );

  // phy kick only inside a response
  assert property (@(posedge clk) disable iff (!rstn) start_tx_ack |-> ack_cts_is_ongoing)
    else begin
      errors++;
      $display("** Error at %0t: start_tx_ack high outside a response", $time);
    end

  assert property (@(posedge clk) disable iff (!rstn) tx_try_complete |=> !tx_try_complete)
    else begin
      errors++;
      $display("** Error at %0t: tx_try_complete longer than one cycle", $time);
    end

  // retry start two edges after backoff_done was seen
  assert property (@(posedge clk) disable iff (!rstn) start_retrans |-> $past(backoff_done, 2))
    else begin
      errors++;
      $display("** Error at %0t: start_retrans without a preceding backoff_done", $time);
    end

  // a finished try leaves no retry pending
  assert property (@(posedge clk) disable iff (!rstn)
    tx_try_complete |-> (!retrans_in_progress && !retrans_trigger))
    else begin
      errors++;
      $display("** Error at %0t: retry still pending when the try completed", $time);
    end

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic watched(input watch_e w);
    case (w)
      W_START_TX_ACK:    return start_tx_ack;
      W_TRY_COMPLETE:    return tx_try_complete;
      W_RETRANS_TRIGGER: return retrans_trigger;
      W_START_RETRANS:   return start_retrans;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic string watch_name(input watch_e w);
    case (w)
      W_START_TX_ACK:    return "start_tx_ack";
      W_TRY_COMPLETE:    return "tx_try_complete";
      W_RETRANS_TRIGGER: return "retrans_trigger";
      default:           return "start_retrans";
    endcase
  endfunction

  // edges counted at negedges, first negedge counts as 1
  task automatic wait_for(input watch_e w, input int limit, output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!watched(w) && n < limit);
    if (!watched(w)) begin
      timeouts++;
      $display("timeout at %0t: %s did not go high within %0d cycles", $time, watch_name(w), limit);
    end
  endtask

  // nav left for the responder, zero when the exchange closes
  function automatic duration_t resp_duration(input logic closes_nav, input duration_t rx_dur);
    int airtime;
    int left;
    airtime = int'(cfg.preamble_sig_time) + 6 * int'(cfg.ofdm_symbol_time);
    left = (rx_dur == 16'd0) ? 0 : int'(rx_dur) - airtime - int'(cfg.sifs_time);
    if (closes_nav) begin
      left = 0;
    end
    return 16'(int'(cfg.duration_extra) + left);
  endfunction

  // 6 Mbps rate, 14 bytes, even parity over both
  function automatic tx_word_t signal_word();
    logic [3:0]  rate;
    logic [11:0] len;
    rate = 4'b1011;
    len  = 12'd14;
    return {46'h0, ^{rate, len}, len, 1'b0, rate};
  endfunction

  // one-cycle fcs_valid, response decision seen on the next edge
  task automatic rx_frame_pulse(input logic [1:0] ftype, input logic [3:0] sub,
                                input logic [15:0] len, input logic mf, input mac_addr_t a1,
                                input logic respond);
    @(posedge clk);
    rx.signal_len <= len;
    rx.fcs_valid  <= 1'b1;
    rx.fc_type    <= ftype;
    rx.fc_subtype <= sub;
    rx.more_frag  <= mf;
    rx.duration   <= dur;
    rx.addr1      <= a1;
    rx.addr2      <= peer;
    @(negedge clk);
    expect_eq("ack_cts_is_ongoing", 64'(ack_cts_is_ongoing), 64'd0);
    @(posedge clk);
    rx.fcs_valid <= 1'b0;
    @(negedge clk);
    expect_eq("ack_cts_is_ongoing", 64'(ack_cts_is_ongoing), 64'(respond));
  endtask

  task automatic fetch_word(input logic [9:0] addr, input string name, input tx_word_t exp);
    @(posedge clk);
    tx_word_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    expect_eq(name, tx_word, exp);
  endtask

  task automatic phy_done_pulse();
    @(posedge clk);
    phy_tx_done <= 1'b1;
    @(posedge clk);
    phy_tx_done <= 1'b0;
  endtask

  task automatic serve_response(input logic [3:0] exp_sub, input duration_t exp_dur);
    int n;
    wait_for(W_START_TX_ACK, 100, n);
    expect_eq("start_tx_ack delay", 64'(n), 64'(cfg.send_ack_wait_top) + 64'd2);
    @(negedge clk);
    expect_eq("start_tx_ack", 64'(start_tx_ack), 64'd0);
    fetch_word(10'd0, "tx_word signal", signal_word());
    fetch_word(10'd2, "tx_word addr_lo",
               {peer[31:0], exp_dur, 8'h00, exp_sub, 2'b01, 2'b00});
    fetch_word(10'd3, "tx_word addr_hi", {48'h0, peer[47:32]});
    phy_done_pulse();
    @(negedge clk);
    expect_eq("ack_cts_is_ongoing", 64'(ack_cts_is_ongoing), 64'd0);
  endtask

  task automatic no_response_window();
    repeat (6) begin
      @(negedge clk);
      expect_eq("ack_cts_is_ongoing", 64'(ack_cts_is_ongoing), 64'd0);
    end
  endtask

  // baseband end a few cycles after the phy reports done
  task automatic bb_end_pulse();
    repeat (3) @(posedge clk);
    pulse_tx_bb_end <= 1'b1;
    @(posedge clk);
    pulse_tx_bb_end <= 1'b0;
  endtask

  // signal of 14 bytes then the ack strobe, entered at a rising edge
  task automatic ack_exchange();
    rx.sig_valid  <= 1'b1;
    rx.signal_len <= 16'd14;
    @(posedge clk);
    rx.sig_valid     <= 1'b0;
    rx.fcs_in_strobe <= 1'b1;
    rx.fc_type       <= FC_TYPE_CTRL;
    rx.fc_subtype    <= SUBTYPE_ACK;
    rx.addr1         <= self_addr;
    @(posedge clk);
    rx.fcs_in_strobe <= 1'b0;
  endtask

  task automatic backoff_retry();
    int n;
    @(posedge clk);
    backoff_done <= 1'b1;
    @(posedge clk);
    backoff_done <= 1'b0;
    wait_for(W_START_RETRANS, 10, n);
    expect_eq("retrans_trigger", 64'(retrans_trigger), 64'd0);
    @(negedge clk);
    expect_eq("start_retrans", 64'(start_retrans), 64'd0);
  endtask

  task automatic compare_status(input logic fail, input retry_cnt_t count);
    @(negedge clk);
    expect_eq("tx_status.fail", 64'(tx_status.fail), 64'(fail));
    expect_eq("tx_status.num_retrans", 64'(tx_status.num_retrans), 64'(count));
  endtask

  initial begin
    seed = 32'hea08;
    rx = '0;
    self_addr = {16'($random(seed)), 32'($random(seed))};
    cfg.preamble_sig_time     = 7'd20;
    cfg.ofdm_symbol_time      = 5'd4;
    cfg.sifs_time             = 7'd16;
    cfg.send_ack_wait_top     = 15'd5;
    cfg.sig_valid_timeout_top = 15'd40;
    cfg.ack_timeout_adj       = 15'd0;
    cfg.duration_extra        = 16'd2;
    cts_torts_disable        = 1'b0;
    phy_tx_done              = 1'b0;
    pulse_tx_bb_end          = 1'b0;
    cts_toself_bb_is_ongoing = 1'b0;
    tx_pkt_need_ack          = 1'b0;
    tx_pkt_retrans_limit     = '0;
    backoff_done             = 1'b0;
    quit_retrans             = 1'b0;
    tx_word_addr             = 10'd1;

    edges = 0;
    while (rstn !== 1'b1 && edges < 20) begin
      @(posedge clk);
      edges++;
    end
    if (rstn !== 1'b1) begin
      timeouts++;
      $display("timeout at %0t: reset was never released", $time);
    end
    @(negedge clk);
    expect_eq("start_tx_ack", 64'(start_tx_ack), 64'd0);
    expect_eq("ack_cts_is_ongoing", 64'(ack_cts_is_ongoing), 64'd0);
    expect_eq("ack_tx_flag", 64'(ack_tx_flag), 64'd0);
    expect_eq("retrans_trigger", 64'(retrans_trigger), 64'd0);
    expect_eq("start_retrans", 64'(start_retrans), 64'd0);
    expect_eq("retrans_in_progress", 64'(retrans_in_progress), 64'd0);
    expect_eq("tx_try_complete", 64'(tx_try_complete), 64'd0);
    expect_eq("tx_status", 64'(tx_status), 64'd0);
    expect_eq("tx_control_state_idle", 64'(tx_control_state_idle), 64'd1);

    // ack for data to self, last fragment then a middle one
    peer = {16'($random(seed)), 32'($random(seed))};
    dur  = 16'd100 + 16'($random(seed) & 32'hfff);
    rx_frame_pulse(FC_TYPE_DATA, 4'h0, 16'd60, 1'b0, self_addr, 1'b1);
    serve_response(SUBTYPE_ACK, resp_duration(1'b1, dur));
    rx_frame_pulse(FC_TYPE_DATA, 4'h0, 16'd60, 1'b1, self_addr, 1'b1);
    serve_response(SUBTYPE_ACK, resp_duration(1'b0, dur));

    // cts for rts, then the cases that get no answer
    peer = {16'($random(seed)), 32'($random(seed))};
    dur  = 16'd100 + 16'($random(seed) & 32'hfff);
    rx_frame_pulse(FC_TYPE_CTRL, SUBTYPE_RTS, 16'd20, 1'b0, self_addr, 1'b1);
    serve_response(SUBTYPE_CTS, resp_duration(1'b0, dur));
    rx_frame_pulse(FC_TYPE_DATA, 4'h0, 16'd60, 1'b0, self_addr ^ 48'h1, 1'b0);
    no_response_window();
    @(posedge clk);
    cts_torts_disable <= 1'b1;
    rx_frame_pulse(FC_TYPE_CTRL, SUBTYPE_RTS, 16'd20, 1'b0, self_addr, 1'b0);
    no_response_window();
    @(posedge clk);
    cts_torts_disable <= 1'b0;

    // own frame without ack
    @(posedge clk);
    tx_pkt_need_ack <= 1'b0;
    phy_done_pulse();
    wait_for(W_TRY_COMPLETE, 20, edges);
    expect_eq("tx_try_complete delay", 64'(edges), 64'd2);
    compare_status(1'b0, 4'd0);

    // one signal timeout, then the ack arrives on the retry
    @(posedge clk);
    tx_pkt_need_ack      <= 1'b1;
    tx_pkt_retrans_limit <= 4'd2;
    model_retries = 0;
    phy_done_pulse();
    bb_end_pulse();
    wait_for(W_RETRANS_TRIGGER, int'(cfg.sig_valid_timeout_top) + 10, edges);
    model_retries++;
    backoff_retry();
    phy_done_pulse();
    bb_end_pulse();
    ack_exchange();
    wait_for(W_TRY_COMPLETE, 20, edges);
    compare_status(1'b0, 4'(model_retries));

    // timeouts until the limit gives up
    @(posedge clk);
    tx_pkt_retrans_limit <= 4'd3;
    phy_done_pulse();
    bb_end_pulse();
    repeat (3) begin
      wait_for(W_RETRANS_TRIGGER, int'(cfg.sig_valid_timeout_top) + 10, edges);
      backoff_retry();
      phy_done_pulse();
      bb_end_pulse();
    end
    wait_for(W_TRY_COMPLETE, int'(cfg.sig_valid_timeout_top) + 10, edges);
    compare_status(1'b1, 4'd3);

    // quit while a retry is pending
    phy_done_pulse();
    bb_end_pulse();
    wait_for(W_RETRANS_TRIGGER, int'(cfg.sig_valid_timeout_top) + 10, edges);
    @(posedge clk);
    quit_retrans <= 1'b1;
    @(posedge clk);
    quit_retrans <= 1'b0;
    wait_for(W_TRY_COMPLETE, 10, edges);
    expect_eq("retrans_in_progress", 64'(retrans_in_progress), 64'd0);
    compare_status(1'b1, 4'd1);

    repeat (4) @(negedge clk);
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- list.f
logic/tx_ctrl_pkg.sv
logic/frame_classifier.sv
logic/response_builder.sv
logic/ack_wait_fsm.sv
logic/tx_control_top.sv
bench/tb_clock_gen.sv
bench/tb_tx_control.sv

//--- Bender.yml
package:
  name: tx_control

sources:
  - logic/tx_ctrl_pkg.sv
  - logic/frame_classifier.sv
  - logic/response_builder.sv
  - logic/ack_wait_fsm.sv
  - logic/tx_control_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_tx_control.sv
